// File: Bender.yml
package:
  name: fetch_front_end

sources:
  - source/nand_cpu_pkg.sv
  - source/cache_request_if.sv
  - source/cache_lookup_if.sv
  - source/i_cache.sv
  - source/instr_memory.sv
  - source/fetch_unit.sv
  - source/fetch_top.sv
  - target: test
    files:
      - verification/fetch_tb.sv

// File: source/cache_lookup_if.sv
interface cache_lookup_if;

    logic valid;
    nand_cpu_pkg::addr_t pc;

    // Combinational answer for the current pc.
    logic hit;
    logic miss;
    nand_cpu_pkg::instr_t data;

    modport fetch (
        output valid, pc,
        input hit, miss, data
    );

    modport cache (
        input valid, pc,
        output hit, miss, data
    );

endinterface

// File: source/cache_request_if.sv
interface cache_request_if;

    // Block address, byte address without its offset bits.
    localparam int OFFSET_BITS =
        $clog2(nand_cpu_pkg::CACHE_BLOCK_SIZE / nand_cpu_pkg::DATA_SIZE);

    logic req;
    logic ack;
    logic [nand_cpu_pkg::ADDR_WIDTH-OFFSET_BITS-1:0] address;
    nand_cpu_pkg::beat_t data; // One beat per cycle after ack.

    modport cache (
        output req, address,
        input ack, data
    );

    modport memory (
        input req, address,
        output ack, data
    );

endinterface

// File: source/fetch_top.sv
module fetch_top #(
    parameter int INDEX_BITS = 4,
    parameter int MEM_LATENCY = 3
) (
    input logic clk,
    input logic n_rst,

    output logic instr_valid,
    input logic instr_ready,
    output nand_cpu_pkg::instr_t instr_data,
    output nand_cpu_pkg::addr_t instr_pc,

    input logic branch_valid,
    input nand_cpu_pkg::addr_t branch_target
);

    cache_lookup_if lookup_bus ();
    cache_request_if request_bus ();

    fetch_unit i_fetch_unit (
        .clk(clk),
        .n_rst(n_rst),
        .lookup(lookup_bus.fetch),
        .instr_valid(instr_valid),
        .instr_ready(instr_ready),
        .instr_data(instr_data),
        .instr_pc(instr_pc),
        .branch_valid(branch_valid),
        .branch_target(branch_target)
    );

    i_cache #(
        .INDEX_BITS(INDEX_BITS)
    ) i_i_cache (
        .clk(clk),
        .n_rst(n_rst),
        .lookup(lookup_bus.cache),
        .cache_request(request_bus.cache)
    );

    instr_memory #(
        .MEM_LATENCY(MEM_LATENCY)
    ) i_instr_memory (
        .clk(clk),
        .n_rst(n_rst),
        .cache_request(request_bus.memory)
    );

endmodule

// File: source/fetch_unit.sv
module fetch_unit (
    input logic clk,
    input logic n_rst,

    cache_lookup_if.fetch lookup,

    output logic instr_valid,
    input logic instr_ready,
    output nand_cpu_pkg::instr_t instr_data,
    output nand_cpu_pkg::addr_t instr_pc,

    input logic branch_valid,
    input nand_cpu_pkg::addr_t branch_target
);

    nand_cpu_pkg::addr_t pc;
    logic active;
    logic transfer;

    // ####################
    // Lookup and output
    // ####################

    assign lookup.valid = active; // Low until first edge after reset.
    assign lookup.pc = pc;

    assign instr_valid = lookup.hit && !lookup.miss;
    assign instr_data = lookup.data;
    assign instr_pc = pc;

    assign transfer = instr_valid && instr_ready;

    // ####################
    // Program counter
    // ####################

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            pc <= '0;
            active <= 1'b0;
        end else begin
            active <= 1'b1;
            if (branch_valid) begin
                // Redirect wins, any byte shown now is dropped.
                pc <= branch_target;
            end else if (transfer) begin
                pc <= pc + 1'b1;
            end
        end
    end

endmodule

// File: source/i_cache.sv
module i_cache #(
    parameter int INDEX_BITS = 4
) (
    input logic clk,
    input logic n_rst,

    cache_lookup_if.cache lookup,

    cache_request_if.cache cache_request
);

    localparam int OFFSET_BITS =
        $clog2(nand_cpu_pkg::CACHE_BLOCK_SIZE / nand_cpu_pkg::DATA_SIZE);
    localparam int TAG_BITS = nand_cpu_pkg::ADDR_WIDTH - INDEX_BITS - OFFSET_BITS;
    localparam int BLOCK_BITS = nand_cpu_pkg::ADDR_WIDTH - OFFSET_BITS;
    localparam int NUM_LINES = 1 << INDEX_BITS;
    localparam int COUNTER_BITS = $clog2(nand_cpu_pkg::BLOCK_BEATS);

    // Lookup address split.
    logic [OFFSET_BITS-1:0] offset;
    logic [INDEX_BITS-1:0] index;
    logic [TAG_BITS-1:0] tag;
    logic tag_match;
    logic start_fill;

    // ####################
    // Line storage
    // ####################

    logic line_valid [NUM_LINES];
    logic [TAG_BITS-1:0] line_tag [NUM_LINES];
    logic [nand_cpu_pkg::CACHE_BLOCK_SIZE-1:0] line_data [NUM_LINES];

    // Refill bookkeeping.
    logic [BLOCK_BITS-1:0] fill_block;
    logic [INDEX_BITS-1:0] fill_index;
    logic [TAG_BITS-1:0] fill_tag;
    logic [COUNTER_BITS-1:0] beat_count;
    logic last_beat;

    nand_cpu_pkg::cache_state_t state;
    nand_cpu_pkg::cache_state_t next_state;

    assign offset = lookup.pc[OFFSET_BITS-1:0];
    assign index = lookup.pc[OFFSET_BITS +: INDEX_BITS];
    assign tag = lookup.pc[nand_cpu_pkg::ADDR_WIDTH-1 -: TAG_BITS];

    assign fill_index = fill_block[INDEX_BITS-1:0];
    assign fill_tag = fill_block[BLOCK_BITS-1 -: TAG_BITS];

    assign tag_match = line_valid[index] && (line_tag[index] == tag);
    assign start_fill = (state == nand_cpu_pkg::READY) && lookup.valid && !tag_match;
    assign last_beat = (beat_count == COUNTER_BITS'(nand_cpu_pkg::BLOCK_BEATS - 1));

    // ####################
    // Lookup response
    // ####################

    always_comb begin
        lookup.hit = 1'b0; // Busy refilling.
        lookup.miss = 1'b1;
        if (state == nand_cpu_pkg::READY) begin
            lookup.hit = lookup.valid && tag_match;
            lookup.miss = lookup.valid && !tag_match;
        end
    end

    assign lookup.data = line_data[index][offset * nand_cpu_pkg::DATA_SIZE +:
                                          nand_cpu_pkg::DATA_SIZE];

    // Request held until ack, dropped in the cycle after.
    assign cache_request.req = (state == nand_cpu_pkg::REQUEST_READ);
    assign cache_request.address = fill_block;

    // ####################
    // Refill controller
    // ####################

    always_comb begin
        next_state = state;
        case (state)
            nand_cpu_pkg::READY: begin
                if (start_fill) begin
                    next_state = nand_cpu_pkg::REQUEST_READ;
                end
            end
            nand_cpu_pkg::REQUEST_READ: begin
                if (cache_request.ack) begin
                    next_state = nand_cpu_pkg::READING;
                end
            end
            nand_cpu_pkg::READING: begin
                if (last_beat) begin
                    next_state = nand_cpu_pkg::READY;
                end
            end
            default: begin
                next_state = nand_cpu_pkg::READY;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            state <= nand_cpu_pkg::READY;
            beat_count <= '0;
            for (int i = 0; i < NUM_LINES; i++) begin
                line_valid[i] <= 1'b0;
            end
        end else begin
            state <= next_state;
            if (state == nand_cpu_pkg::REQUEST_READ) begin
                beat_count <= '0;
            end else if (state == nand_cpu_pkg::READING) begin
                beat_count <= beat_count + 1'b1;
                if (last_beat) begin
                    line_valid[fill_index] <= 1'b1; // Line usable from next cycle.
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_fill) begin
            fill_block <= lookup.pc[nand_cpu_pkg::ADDR_WIDTH-1:OFFSET_BITS];
        end
        if (state == nand_cpu_pkg::READING) begin
            line_data[fill_index][beat_count * nand_cpu_pkg::MEM_TRANS_SIZE +:
                                  nand_cpu_pkg::MEM_TRANS_SIZE] <= cache_request.data;
            if (last_beat) begin
                line_tag[fill_index] <= fill_tag;
            end
        end
    end

endmodule

// File: source/instr_memory.sv
module instr_memory #(
    parameter int MEM_LATENCY = 3
) (
    input logic clk,
    input logic n_rst,

    cache_request_if.memory cache_request
);

    localparam int OFFSET_BITS =
        $clog2(nand_cpu_pkg::CACHE_BLOCK_SIZE / nand_cpu_pkg::DATA_SIZE);
    localparam int BLOCK_BITS = nand_cpu_pkg::ADDR_WIDTH - OFFSET_BITS;
    localparam int LAT_BITS = $clog2(MEM_LATENCY + 1);
    localparam int COUNTER_BITS = $clog2(nand_cpu_pkg::BLOCK_BEATS);
    localparam int BEAT_BYTES = nand_cpu_pkg::MEM_TRANS_SIZE / nand_cpu_pkg::DATA_SIZE;
    localparam int BYTE_BITS = $clog2(BEAT_BYTES);

    logic [LAT_BITS-1:0] lat_count;
    logic ack;
    logic sending;
    logic [COUNTER_BITS-1:0] beat_count;
    logic [BLOCK_BITS-1:0] block;
    nand_cpu_pkg::addr_t base;
    nand_cpu_pkg::beat_t beat;

    // Low byte of a times 37, xor high byte.
    function automatic nand_cpu_pkg::instr_t content(input nand_cpu_pkg::addr_t a);
        return nand_cpu_pkg::instr_t'(a[7:0] * 8'd37) ^ a[15:8];
    endfunction

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            lat_count <= '0;
            ack <= 1'b0;
            sending <= 1'b0;
            beat_count <= '0;
        end else begin
            ack <= 1'b0;
            if (sending) begin
                beat_count <= beat_count + 1'b1;
                if (beat_count == COUNTER_BITS'(nand_cpu_pkg::BLOCK_BEATS - 1)) begin
                    sending <= 1'b0;
                end
            end else if (ack) begin
                sending <= 1'b1; // Burst starts right after ack.
                beat_count <= '0;
            end else if (cache_request.req) begin
                if (lat_count == LAT_BITS'(MEM_LATENCY - 1)) begin
                    ack <= 1'b1;
                    lat_count <= '0;
                end else begin
                    lat_count <= lat_count + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ack) begin
            block <= cache_request.address;
        end
    end

    // ####################
    // Beat assembly
    // ####################

    assign base = {block, beat_count, {BYTE_BITS{1'b0}}};

    always_comb begin
        for (int i = 0; i < BEAT_BYTES; i++) begin
            beat[i * nand_cpu_pkg::DATA_SIZE +: nand_cpu_pkg::DATA_SIZE] =
                content(base + nand_cpu_pkg::addr_t'(i)); // Lower byte in low half.
        end
    end

    assign cache_request.ack = ack;
    assign cache_request.data = beat;

endmodule

// File: source/nand_cpu_pkg.sv
package nand_cpu_pkg;

    // ####################
    // Widths
    // ####################

    // Byte address width.
    localparam int ADDR_WIDTH = 16;

    // One instruction byte.
    localparam int DATA_SIZE = 8;

    // Bits per cache line, eight bytes.
    localparam int CACHE_BLOCK_SIZE = 64;

    // Bits per memory beat.
    localparam int MEM_TRANS_SIZE = 16;

    localparam int BLOCK_BEATS = CACHE_BLOCK_SIZE / MEM_TRANS_SIZE; // Beats per block.

    // ####################
    // Types
    // ####################

    typedef logic [ADDR_WIDTH-1:0] addr_t;

    typedef logic [DATA_SIZE-1:0] instr_t;

    typedef logic [MEM_TRANS_SIZE-1:0] beat_t;

    // Refill controller.
    typedef enum logic [1:0] {
        READY,
        REQUEST_READ,
        READING
    } cache_state_t;

endpackage

// File: verification/fetch_tb.sv
module fetch_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] SEED = 32'h320b_3513;
    localparam int WAIT_CYCLES = 200; // Idle cycles before a wait gives up.

    logic clk = 1'b0;
    logic n_rst;
    logic instr_valid;
    logic instr_ready;
    nand_cpu_pkg::instr_t instr_data;
    nand_cpu_pkg::addr_t instr_pc;
    logic branch_valid;
    nand_cpu_pkg::addr_t branch_target;

    logic [31:0] rng;
    nand_cpu_pkg::addr_t exp_pc;
    nand_cpu_pkg::addr_t prev_pc;
    nand_cpu_pkg::instr_t prev_data;
    logic prev_hold; // Last edge showed a byte that was held.
    logic first_cycle;
    int xfer_count = 0;

    always #50 clk = ~clk;

    fetch_top i_fetch_top (
        .clk(clk),
        .n_rst(n_rst),
        .instr_valid(instr_valid),
        .instr_ready(instr_ready),
        .instr_data(instr_data),
        .instr_pc(instr_pc),
        .branch_valid(branch_valid),
        .branch_target(branch_target)
    );

    // ####################
    // Reference and checks
    // ####################

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic nand_cpu_pkg::instr_t expected_byte(input nand_cpu_pkg::addr_t a);
        logic [15:0] prod;
        prod = {8'h00, a[7:0]} * 16'd37;
        return prod[7:0] ^ a[15:8];
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string what);
        abort_run($sformatf("MISMATCH at %0d ns: %s", $time, what));
    endtask

    task automatic check_valid(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            report_mismatch($sformatf("%s is %b, expected %b", what, actual, expected));
        end
    endtask

    task automatic check_pc(input nand_cpu_pkg::addr_t actual,
                            input nand_cpu_pkg::addr_t expected);
        if (actual !== expected) begin
            report_mismatch($sformatf("instr_pc is %h, expected %h", actual, expected));
        end
    endtask

    task automatic check_byte(input nand_cpu_pkg::instr_t actual,
                              input nand_cpu_pkg::instr_t expected,
                              input nand_cpu_pkg::addr_t at);
        if (actual !== expected) begin
            report_mismatch($sformatf("byte at %h is %h, expected %h", at, actual, expected));
        end
    endtask

    task automatic check_stable(input nand_cpu_pkg::addr_t pc_now,
                                input nand_cpu_pkg::addr_t pc_before,
                                input nand_cpu_pkg::instr_t data_now,
                                input nand_cpu_pkg::instr_t data_before);
        if (pc_now !== pc_before || data_now !== data_before) begin
            report_mismatch($sformatf("held output moved from %h/%h to %h/%h",
                                      pc_before, data_before, pc_now, data_now));
        end
    endtask

    // Samples the pre-edge values the DUT acts on.
    always @(posedge clk) begin
        if (!n_rst) begin
            check_valid(instr_valid, 1'b0, "instr_valid in reset");
            exp_pc = '0;
            first_cycle = 1'b1;
            prev_hold = 1'b0;
        end else begin
            if (first_cycle) check_valid(instr_valid, 1'b0, "instr_valid after reset");
            first_cycle = 1'b0;
            if (prev_hold && instr_valid) begin
                check_stable(instr_pc, prev_pc, instr_data, prev_data);
            end
            if (branch_valid) begin
                exp_pc = branch_target; // Redirect drops the shown byte.
            end else if (instr_valid && instr_ready) begin
                check_pc(instr_pc, exp_pc);
                check_byte(instr_data, expected_byte(exp_pc), exp_pc);
                exp_pc = exp_pc + 1'b1;
                xfer_count <= xfer_count + 1;
            end
            prev_hold = instr_valid && !instr_ready && !branch_valid;
            prev_pc = instr_pc;
            prev_data = instr_data;
        end
    end

    // ####################
    // Stimulus
    // ####################

    task automatic drive_random_ready();
        rng = lcg_step(rng);
        instr_ready <= (rng[31:30] != 2'b00);
    endtask

    task automatic run_until_transfers(input int n, input logic random_ready);
        int target;
        int last;
        int idle;
        target = xfer_count + n;
        last = xfer_count;
        idle = 0;
        while (xfer_count < target) begin
            @(posedge clk);
            if (random_ready) drive_random_ready();
            idle = (xfer_count != last) ? 0 : idle + 1;
            last = xfer_count;
            if (idle > WAIT_CYCLES) abort_run("Timeout: no instruction arrived in time.");
        end
    endtask

    task automatic wait_valid_high();
        int idle;
        idle = 0;
        do begin
            @(posedge clk);
            idle++;
            if (idle > WAIT_CYCLES) abort_run("Timeout: no instruction arrived in time.");
        end while (!instr_valid);
    endtask

    task automatic redirect(input nand_cpu_pkg::addr_t target);
        @(posedge clk);
        branch_valid <= 1'b1;
        branch_target <= target;
        @(posedge clk);
        branch_valid <= 1'b0;
    endtask

    initial begin
        int delay;
        rng = SEED;
        n_rst = 1'b0;
        instr_ready = 1'b1;
        branch_valid = 1'b0;
        branch_target = '0;
        repeat (3) @(posedge clk);
        n_rst <= 1'b1;
        run_until_transfers(300, 1'b0); // Sequential run wraps the cache.
        run_until_transfers(200, 1'b1);
        for (int k = 0; k < 24; k++) begin
            rng = lcg_step(rng);
            delay = rng[27:24];
            repeat (delay) begin
                @(posedge clk);
                drive_random_ready();
            end
            rng = lcg_step(rng);
            redirect(rng[31:16]); // Often lands inside a fill.
            run_until_transfers(3, 1'b1);
        end
        // Resident loop on one block.
        instr_ready <= 1'b1;
        redirect(16'h2a40);
        run_until_transfers(8, 1'b0);
        instr_ready <= 1'b0;
        wait_valid_high();
        redirect(16'h2a40);
        instr_ready <= 1'b1;
        repeat (8) begin
            @(posedge clk);
            check_valid(instr_valid, 1'b1, "instr_valid in resident loop");
        end
        // Same index, different tags.
        for (int k = 0; k < 6; k++) begin
            redirect(16'h1238);
            run_until_transfers(3, 1'b0);
            redirect(16'h9238);
            run_until_transfers(3, 1'b0);
        end
        $display("Simulation passed");
        $finish;
    end

endmodule

// File: vlog.f
source/nand_cpu_pkg.sv
source/cache_request_if.sv
source/cache_lookup_if.sv
source/i_cache.sv
source/instr_memory.sv
source/fetch_unit.sv
source/fetch_top.sv
verification/fetch_tb.sv
